/* hdl/glb_pkg.sv */
//----------------------------------------
// glb load package
// address layout, widths, load header
// and dma mode encoding
//----------------------------------------
package glb_pkg;

    // byte address: 2:0 byte, 4:3 bank, 11:5 row
    localparam int GLB_ADDR_WIDTH  = 12;
    localparam int BANK_DATA_WIDTH = 64;
    localparam int CGRA_DATA_WIDTH = 16;
    localparam int LANES           = BANK_DATA_WIDTH / CGRA_DATA_WIDTH;
    localparam int LANE_WIDTH      = $clog2(LANES);
    // lane select sits right above the byte-in-lane bit
    localparam int LANE_LSB        = $clog2(CGRA_DATA_WIDTH / 8);
    // bits below this are inside one bank word
    localparam int BYTE_OFFSET     = $clog2(BANK_DATA_WIDTH / 8);

    localparam int LOOP_LEVEL  = 2;
    localparam int CNT_WIDTH   = 8;
    localparam int QUEUE_DEPTH = 2;
    localparam int QSEL_WIDTH  = $clog2(QUEUE_DEPTH);

    typedef enum logic [1:0] {
        OFF,
        NORMAL,
        REPEAT,
        AUTO_INCR
    } dma_mode_t;

    // one queue slot
    // num_active of 0 means no gaps, range of 0 means level unused
    typedef struct packed {
        logic                                 valid;
        logic [GLB_ADDR_WIDTH-1:0]            start_addr;
        logic [CNT_WIDTH-1:0]                 num_active;
        logic [CNT_WIDTH-1:0]                 num_inactive;
        logic [LOOP_LEVEL-1:0][CNT_WIDTH-1:0] range;
        // byte stride per level
        logic [LOOP_LEVEL-1:0][CNT_WIDTH-1:0] stride;
    } dma_ld_header_t;

endpackage

/* hdl/glb_rd_if.sv */
//----------------------------------------
// glb bank interface
// read/write request and read response
// between dma, router, banks and merger
//----------------------------------------
`timescale 1ns/1ps

interface glb_rd_if import glb_pkg::*; ();

    // request side, single-cycle strobes
    logic                       rd_en;
    logic [GLB_ADDR_WIDTH-1:0]  rd_addr;
    logic                       wr_en;
    logic [GLB_ADDR_WIDTH-1:0]  wr_addr;
    logic [BANK_DATA_WIDTH-1:0] wr_data;

    // response side, fixed latency after rd_en
    logic [BANK_DATA_WIDTH-1:0] rd_data;
    logic                       rd_data_valid;

    modport master (
        output rd_en, rd_addr, wr_en, wr_addr, wr_data,
        input  rd_data, rd_data_valid
    );

    modport slave (
        input  rd_en, rd_addr, wr_en, wr_addr, wr_data,
        output rd_data, rd_data_valid
    );

    // merger reads the bank instances, drives the dma instance
    modport merge (
        output rd_data, rd_data_valid
    );

endinterface

/* hdl/glb_load_dma.sv */
//----------------------------------------
// glb load dma
// header queue, two-level strided address
// walk with duty cycle, merged bank reads,
// lane select and done pulse
//----------------------------------------
`timescale 1ns/1ps

module glb_load_dma
    import glb_pkg::*;
#(
    parameter int RD_LATENCY = 4
) (
    input  logic                       clk,
    input  logic                       reset,
    input  dma_mode_t                  cfg_mode,
    input  logic                       cfg_hdr_wr,
    input  logic [QSEL_WIDTH-1:0]      cfg_hdr_idx,
    input  dma_ld_header_t             cfg_hdr,
    input  logic                       start_pulse,
    output logic [CGRA_DATA_WIDTH-1:0] stream_data,
    output logic                       stream_data_valid,
    output logic [QUEUE_DEPTH-1:0]     invalidate_pulse,
    output logic                       done_pulse,
    glb_rd_if.master                   bank
);

    // header queue
    dma_ld_header_t                        hdr_q [QUEUE_DEPTH];
    logic [QUEUE_DEPTH-1:0]                hdr_valid;
    logic [QSEL_WIDTH-1:0]                 q_sel;
    logic [QSEL_WIDTH-1:0]                 sel;
    logic                                  accept;

    // run state
    dma_ld_header_t                        cur;
    logic                                  run;
    logic                                  active;
    logic                                  first;
    logic [CNT_WIDTH-1:0]                  act_cnt;
    logic [CNT_WIDTH-1:0]                  inact_cnt;
    logic [LOOP_LEVEL-1:0][CNT_WIDTH-1:0]  itr;
    logic [LOOP_LEVEL-1:0][CNT_WIDTH-1:0]  itr_next;
    logic [LOOP_LEVEL-1:0]                 lvl_end;
    logic                                  last_word;
    logic                                  burst_end;
    logic                                  issue;

    // address and read merge
    logic [GLB_ADDR_WIDTH-1:0]             word_addr;
    logic [GLB_ADDR_WIDTH-BYTE_OFFSET-1:0] prev_word;

    // response alignment
    logic [RD_LATENCY-1:0]                 dly_valid;
    logic [RD_LATENCY-1:0]                 dly_last;
    logic [RD_LATENCY-1:0][LANE_WIDTH-1:0] dly_lane;
    logic [BANK_DATA_WIDTH-1:0]            cache;
    logic [LANES-1:0][CGRA_DATA_WIDTH-1:0] resp_lanes;
    logic                                  stream_last;

    // only auto-incr walks the queue, other modes pin slot 0
    assign sel = (cfg_mode == AUTO_INCR) ? q_sel : '0;

    // ignored while a stream runs
    assign accept = start_pulse && (cfg_mode != OFF) && hdr_valid[sel]
                    && (hdr_q[sel].range[0] != '0) && !run;

    always_ff @(posedge clk) begin
        if (cfg_hdr_wr) begin
            hdr_q[cfg_hdr_idx] <= cfg_hdr;
        end
    end

    // slot valid, a fresh write wins over invalidate
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hdr_valid <= '0;
        end else begin
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                if (cfg_hdr_wr && (cfg_hdr_idx == i)) begin
                    hdr_valid[i] <= cfg_hdr.valid;
                end else if (invalidate_pulse[i]) begin
                    hdr_valid[i] <= 1'b0;
                end
            end
        end
    end

    // iterator with carry chain, inner level first
    always_comb begin
        logic carry;
        carry     = 1'b1;
        last_word = 1'b1;
        for (int l = 0; l < LOOP_LEVEL; l++) begin
            // unused level counts as a single pass
            lvl_end[l]  = (cur.range[l] == '0) || (itr[l] == cur.range[l] - 1'b1);
            last_word   = last_word && lvl_end[l];
            itr_next[l] = itr[l];
            if (carry) begin
                itr_next[l] = lvl_end[l] ? '0 : itr[l] + 1'b1;
            end
            carry = carry && lvl_end[l];
        end
    end

    // start + sum of itr * stride
    always_comb begin
        word_addr = cur.start_addr;
        for (int l = 0; l < LOOP_LEVEL; l++) begin
            word_addr = word_addr
                        + GLB_ADDR_WIDTH'(itr[l]) * GLB_ADDR_WIDTH'(cur.stride[l]);
        end
    end

    // gaps only when both duty fields are set
    assign burst_end = (cur.num_active != '0) && (cur.num_inactive != '0)
                       && (act_cnt == cur.num_active - 1'b1);

    assign issue = run && active;

    // read only on the first word or a new bank word
    assign bank.rd_en   = issue
                          && (first || (word_addr[GLB_ADDR_WIDTH-1:BYTE_OFFSET] != prev_word));
    assign bank.rd_addr = word_addr;

    // header is latched so the queue can move on
    always_ff @(posedge clk) begin
        if (accept) begin
            cur <= hdr_q[sel];
        end
        if (issue) begin
            prev_word <= word_addr[GLB_ADDR_WIDTH-1:BYTE_OFFSET];
        end
    end

    // run control, duty cycle and queue select
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            run              <= 1'b0;
            active           <= 1'b0;
            first            <= 1'b0;
            act_cnt          <= '0;
            inact_cnt        <= '0;
            itr              <= '0;
            q_sel            <= '0;
            invalidate_pulse <= '0;
        end else begin
            invalidate_pulse <= '0;
            if (accept) begin
                run       <= 1'b1;
                active    <= 1'b1;
                first     <= 1'b1;
                act_cnt   <= '0;
                inact_cnt <= '0;
                itr       <= '0;
                // repeat keeps its slot
                if (cfg_mode != REPEAT) begin
                    invalidate_pulse[sel] <= 1'b1;
                end
                if (cfg_mode == AUTO_INCR) begin
                    q_sel <= (q_sel == QSEL_WIDTH'(QUEUE_DEPTH - 1)) ? '0 : q_sel + 1'b1;
                end
            end else if (run) begin
                if (active) begin
                    first   <= 1'b0;
                    itr     <= itr_next;
                    act_cnt <= act_cnt + 1'b1;
                    if (last_word) begin
                        run    <= 1'b0;
                        active <= 1'b0;
                    end else if (burst_end) begin
                        active    <= 1'b0;
                        inact_cnt <= '0;
                    end
                end else begin
                    inact_cnt <= inact_cnt + 1'b1;
                    // idle for exactly num_inactive cycles
                    if (inact_cnt == cur.num_inactive - 1'b1) begin
                        active  <= 1'b1;
                        act_cnt <= '0;
                    end
                end
            end
        end
    end

    // merged words reuse the last returned bank word
    assign resp_lanes = bank.rd_data_valid ? bank.rd_data : cache;

    always_ff @(posedge clk) begin
        if (bank.rd_data_valid) begin
            cache <= bank.rd_data;
        end
        dly_lane <= {dly_lane[RD_LATENCY-2:0], word_addr[LANE_LSB +: LANE_WIDTH]};
        if (dly_valid[RD_LATENCY-1]) begin
            stream_data <= resp_lanes[dly_lane[RD_LATENCY-1]];
        end
    end

    // tap lines up with the response, one more stage to the fabric
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dly_valid         <= '0;
            dly_last          <= '0;
            stream_data_valid <= 1'b0;
            stream_last       <= 1'b0;
            done_pulse        <= 1'b0;
        end else begin
            dly_valid         <= {dly_valid[RD_LATENCY-2:0], issue};
            dly_last          <= {dly_last[RD_LATENCY-2:0], issue && last_word};
            stream_data_valid <= dly_valid[RD_LATENCY-1];
            stream_last       <= dly_last[RD_LATENCY-1];
            // cycle after the last valid
            done_pulse        <= stream_data_valid && stream_last;
        end
    end

endmodule

/* hdl/glb_bank_router.sv */
//----------------------------------------
// glb bank router
// registers dma requests and steers them
// to one bank by address bits 4:3
//----------------------------------------
`timescale 1ns/1ps

module glb_bank_router
    import glb_pkg::*;
#(
    parameter int NUM_BANKS = 4
) (
    input  logic     clk,
    input  logic     reset,
    glb_rd_if.slave  dma,
    glb_rd_if.master banks [NUM_BANKS]
);

    localparam int BANK_BITS = $clog2(NUM_BANKS);

    logic                       rd_en_q;
    logic                       wr_en_q;
    logic [GLB_ADDR_WIDTH-1:0]  rd_addr_q;
    logic [GLB_ADDR_WIDTH-1:0]  wr_addr_q;
    logic [BANK_DATA_WIDTH-1:0] wr_data_q;
    logic [BANK_BITS-1:0]       rd_bank;
    logic [BANK_BITS-1:0]       wr_bank;

    // drop bank bits, row moves down next to the byte offset
    function automatic logic [GLB_ADDR_WIDTH-1:0] strip_bank(
        input logic [GLB_ADDR_WIDTH-1:0] addr
    );
        return {{BANK_BITS{1'b0}},
                addr[GLB_ADDR_WIDTH-1:BYTE_OFFSET+BANK_BITS],
                addr[BYTE_OFFSET-1:0]};
    endfunction

    // the one router stage counted in the read latency
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_en_q <= 1'b0;
            wr_en_q <= 1'b0;
        end else begin
            rd_en_q <= dma.rd_en;
            wr_en_q <= dma.wr_en;
        end
    end

    always_ff @(posedge clk) begin
        rd_addr_q <= dma.rd_addr;
        wr_addr_q <= dma.wr_addr;
        wr_data_q <= dma.wr_data;
    end

    // banks interleaved by bank word
    assign rd_bank = rd_addr_q[BYTE_OFFSET +: BANK_BITS];
    assign wr_bank = wr_addr_q[BYTE_OFFSET +: BANK_BITS];

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_route
        assign banks[b].rd_en   = rd_en_q && (rd_bank == BANK_BITS'(b));
        assign banks[b].rd_addr = strip_bank(rd_addr_q);
        assign banks[b].wr_en   = wr_en_q && (wr_bank == BANK_BITS'(b));
        assign banks[b].wr_addr = strip_bank(wr_addr_q);
        assign banks[b].wr_data = wr_data_q;
    end

endmodule

/* hdl/glb_bank.sv */
//----------------------------------------
// glb bank
// 64-bit sram model, two-cycle read
//----------------------------------------
`timescale 1ns/1ps

module glb_bank
    import glb_pkg::*;
#(
    parameter int ROWS = 128
) (
    input  logic    clk,
    input  logic    reset,
    glb_rd_if.slave port
);

    localparam int ROW_WIDTH = $clog2(ROWS);

    logic [BANK_DATA_WIDTH-1:0] mem [ROWS];
    logic [BANK_DATA_WIDTH-1:0] rd_data_s1;
    logic                       rd_valid_s1;
    logic [ROW_WIDTH-1:0]       rd_row;
    logic [ROW_WIDTH-1:0]       wr_row;

    // router already stripped the bank bits
    assign rd_row = port.rd_addr[BYTE_OFFSET +: ROW_WIDTH];
    assign wr_row = port.wr_addr[BYTE_OFFSET +: ROW_WIDTH];

    // array read then output register
    always_ff @(posedge clk) begin
        if (port.wr_en) begin
            mem[wr_row] <= port.wr_data;
        end
        if (port.rd_en) begin
            rd_data_s1 <= mem[rd_row];
        end
        if (rd_valid_s1) begin
            port.rd_data <= rd_data_s1;
        end
    end

    // valid follows rd_en by two cycles
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_valid_s1        <= 1'b0;
            port.rd_data_valid <= 1'b0;
        end else begin
            rd_valid_s1        <= port.rd_en;
            port.rd_data_valid <= rd_valid_s1;
        end
    end

endmodule

/* hdl/glb_rdrs_merge.sv */
//----------------------------------------
// glb read response merge
// picks the responding bank, registers
// its word toward the dma
//----------------------------------------
`timescale 1ns/1ps

module glb_rdrs_merge
    import glb_pkg::*;
#(
    parameter int NUM_BANKS = 4
) (
    input  logic    clk,
    input  logic    reset,
    glb_rd_if.merge banks [NUM_BANKS],
    glb_rd_if.merge dma
);

    logic [NUM_BANKS-1:0]       bank_valid;
    logic [BANK_DATA_WIDTH-1:0] bank_data [NUM_BANKS];
    logic [BANK_DATA_WIDTH-1:0] sel_data;

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_collect
        assign bank_valid[b] = banks[b].rd_data_valid;
        assign bank_data[b]  = banks[b].rd_data;
    end

    // one read per cycle upstream, so at most one bank answers
    always_comb begin
        sel_data = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (bank_valid[b]) begin
                sel_data = bank_data[b];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (|bank_valid) begin
            dma.rd_data <= sel_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dma.rd_data_valid <= 1'b0;
        end else begin
            dma.rd_data_valid <= |bank_valid;
        end
    end

endmodule

/* hdl/glb_load_top.sv */
//----------------------------------------
// glb load top
// dma, bank router, bank array and
// response merge of the load path
//----------------------------------------
`timescale 1ns/1ps

module glb_load_top
    import glb_pkg::*;
#(
    // address bits 4:3 assume four banks
    parameter int NUM_BANKS = 4,
    parameter int ROWS      = 128
) (
    input  logic                       clk,
    input  logic                       reset,
    input  dma_mode_t                  cfg_mode,
    input  logic                       cfg_hdr_wr,
    input  logic [QSEL_WIDTH-1:0]      cfg_hdr_idx,
    input  logic [GLB_ADDR_WIDTH-1:0]  cfg_start_addr,
    input  logic [CNT_WIDTH-1:0]       cfg_num_active,
    input  logic [CNT_WIDTH-1:0]       cfg_num_inactive,
    input  logic [CNT_WIDTH-1:0]       cfg_range0,
    input  logic [CNT_WIDTH-1:0]       cfg_range1,
    input  logic [CNT_WIDTH-1:0]       cfg_stride0,
    input  logic [CNT_WIDTH-1:0]       cfg_stride1,
    input  logic                       mem_wr_en,
    input  logic [GLB_ADDR_WIDTH-1:0]  mem_wr_addr,
    input  logic [BANK_DATA_WIDTH-1:0] mem_wr_data,
    input  logic                       start_pulse,
    output logic [CGRA_DATA_WIDTH-1:0] stream_data,
    output logic                       stream_data_valid,
    output logic [QUEUE_DEPTH-1:0]     invalidate_pulse,
    output logic                       done_pulse
);

    // request to response depth, stage by stage
    localparam int ROUTER_STAGES = 1;
    localparam int BANK_STAGES   = 2;
    localparam int MERGE_STAGES  = 1;
    localparam int RD_LATENCY    = ROUTER_STAGES + BANK_STAGES + MERGE_STAGES;

    dma_ld_header_t cfg_hdr;

    glb_rd_if dma_if ();
    glb_rd_if bank_if [NUM_BANKS] ();

    // header pack, slot turns valid on write
    assign cfg_hdr.valid        = cfg_hdr_wr;
    assign cfg_hdr.start_addr   = cfg_start_addr;
    assign cfg_hdr.num_active   = cfg_num_active;
    assign cfg_hdr.num_inactive = cfg_num_inactive;
    assign cfg_hdr.range        = {cfg_range1, cfg_range0};
    assign cfg_hdr.stride       = {cfg_stride1, cfg_stride0};

    // bank fill shares the router path with dma reads
    assign dma_if.wr_en   = mem_wr_en;
    assign dma_if.wr_addr = mem_wr_addr;
    assign dma_if.wr_data = mem_wr_data;

    glb_load_dma #(
        .RD_LATENCY (RD_LATENCY)
    ) u_load_dma (
        .clk               (clk),
        .reset             (reset),
        .cfg_mode          (cfg_mode),
        .cfg_hdr_wr        (cfg_hdr_wr),
        .cfg_hdr_idx       (cfg_hdr_idx),
        .cfg_hdr           (cfg_hdr),
        .start_pulse       (start_pulse),
        .stream_data       (stream_data),
        .stream_data_valid (stream_data_valid),
        .invalidate_pulse  (invalidate_pulse),
        .done_pulse        (done_pulse),
        .bank              (dma_if)
    );

    glb_bank_router #(
        .NUM_BANKS (NUM_BANKS)
    ) u_bank_router (
        .clk   (clk),
        .reset (reset),
        .dma   (dma_if),
        .banks (bank_if)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        glb_bank #(
            .ROWS (ROWS)
        ) u_bank (
            .clk   (clk),
            .reset (reset),
            .port  (bank_if[b])
        );
    end

    glb_rdrs_merge #(
        .NUM_BANKS (NUM_BANKS)
    ) u_rdrs_merge (
        .clk   (clk),
        .reset (reset),
        .banks (bank_if),
        .dma   (dma_if)
    );

endmodule

/* tb/glb_load_tb.sv */
//----------------------------------------
// glb load testbench
// file-driven load streams checked
// against a memory and address model
//----------------------------------------
`timescale 1ns/1ps

module glb_load_tb
    import glb_pkg::*;
();

    localparam int TIMEOUT = 2000;
    localparam int WORDS   = 1 << (GLB_ADDR_WIDTH - BYTE_OFFSET);

    logic                       clk;
    logic                       reset;
    dma_mode_t                  cfg_mode;
    logic                       cfg_hdr_wr;
    logic [QSEL_WIDTH-1:0]      cfg_hdr_idx;
    logic [GLB_ADDR_WIDTH-1:0]  cfg_start_addr;
    logic [CNT_WIDTH-1:0]       cfg_num_active;
    logic [CNT_WIDTH-1:0]       cfg_num_inactive;
    logic [CNT_WIDTH-1:0]       cfg_range0;
    logic [CNT_WIDTH-1:0]       cfg_range1;
    logic [CNT_WIDTH-1:0]       cfg_stride0;
    logic [CNT_WIDTH-1:0]       cfg_stride1;
    logic                       mem_wr_en;
    logic [GLB_ADDR_WIDTH-1:0]  mem_wr_addr;
    logic [BANK_DATA_WIDTH-1:0] mem_wr_data;
    logic                       start_pulse;
    logic [CGRA_DATA_WIDTH-1:0] stream_data;
    logic                       stream_data_valid;
    logic [QUEUE_DEPTH-1:0]     invalidate_pulse;
    logic                       done_pulse;

    // reference state
    logic [BANK_DATA_WIDTH-1:0] mem_model [WORDS];
    dma_ld_header_t             hdr_model [QUEUE_DEPTH];
    dma_mode_t                  mode_model;

    // monitor records
    logic [CGRA_DATA_WIDTH-1:0] got_data [$];
    int                         got_cyc [$];
    int                         cyc;
    int                         done_cnt;
    int                         done_cyc;
    int                         inv_cnt [QUEUE_DEPTH];

    int                         errors;
    int                         tests_passed;
    int                         tests_failed;
    int                         seed;
    int                         fd;
    string                      kind;
    string                      line;
    string                      tname;
    string                      mname;
    int                         slot;
    int                         v [7];
    logic [GLB_ADDR_WIDTH-1:0]  faddr;
    logic [BANK_DATA_WIDTH-1:0] fdata;

    glb_load_top u_glb_load_top (
        .clk               (clk),
        .reset             (reset),
        .cfg_mode          (cfg_mode),
        .cfg_hdr_wr        (cfg_hdr_wr),
        .cfg_hdr_idx       (cfg_hdr_idx),
        .cfg_start_addr    (cfg_start_addr),
        .cfg_num_active    (cfg_num_active),
        .cfg_num_inactive  (cfg_num_inactive),
        .cfg_range0        (cfg_range0),
        .cfg_range1        (cfg_range1),
        .cfg_stride0       (cfg_stride0),
        .cfg_stride1       (cfg_stride1),
        .mem_wr_en         (mem_wr_en),
        .mem_wr_addr       (mem_wr_addr),
        .mem_wr_data       (mem_wr_data),
        .start_pulse       (start_pulse),
        .stream_data       (stream_data),
        .stream_data_valid (stream_data_valid),
        .invalidate_pulse  (invalidate_pulse),
        .done_pulse        (done_pulse)
    );

    always #5 clk = ~clk;

    // sample on the edge, outputs settled since the last one
    always @(posedge clk) begin
        cyc++;
        if (!reset) begin
            if (stream_data_valid) begin
                got_data.push_back(stream_data);
                got_cyc.push_back(cyc);
            end
            if (done_pulse) begin
                done_cnt++;
                done_cyc = cyc;
            end
            for (int s = 0; s < QUEUE_DEPTH; s++) begin
                if (invalidate_pulse[s]) begin
                    inv_cnt[s]++;
                end
            end
        end
    end

    task automatic check_word(
        input string                      name,
        input logic [CGRA_DATA_WIDTH-1:0] expected,
        input logic [CGRA_DATA_WIDTH-1:0] actual
    );
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_gap(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    // lane of the bank word holding this byte address
    function automatic logic [CGRA_DATA_WIDTH-1:0] lane_of(
        input logic [GLB_ADDR_WIDTH-1:0] addr
    );
        logic [BANK_DATA_WIDTH-1:0] word;
        int                         lane;
        word = mem_model[addr[GLB_ADDR_WIDTH-1:BYTE_OFFSET]];
        lane = addr[LANE_LSB +: LANE_WIDTH];
        return word[lane*CGRA_DATA_WIDTH +: CGRA_DATA_WIDTH];
    endfunction

    task automatic write_mem(
        input logic [GLB_ADDR_WIDTH-1:0]  addr,
        input logic [BANK_DATA_WIDTH-1:0] data
    );
        @(posedge clk);
        mem_wr_en   <= 1'b1;
        mem_wr_addr <= addr;
        mem_wr_data <= data;
        @(posedge clk);
        mem_wr_en <= 1'b0;
        mem_model[addr[GLB_ADDR_WIDTH-1:BYTE_OFFSET]] = data;
    endtask

    // v holds start, active, inactive, range0, range1, stride0, stride1
    task automatic write_hdr(input int idx);
        @(posedge clk);
        cfg_hdr_wr       <= 1'b1;
        cfg_hdr_idx      <= QSEL_WIDTH'(idx);
        cfg_start_addr   <= GLB_ADDR_WIDTH'(v[0]);
        cfg_num_active   <= CNT_WIDTH'(v[1]);
        cfg_num_inactive <= CNT_WIDTH'(v[2]);
        cfg_range0       <= CNT_WIDTH'(v[3]);
        cfg_range1       <= CNT_WIDTH'(v[4]);
        cfg_stride0      <= CNT_WIDTH'(v[5]);
        cfg_stride1      <= CNT_WIDTH'(v[6]);
        @(posedge clk);
        cfg_hdr_wr <= 1'b0;
        hdr_model[idx].valid        = 1'b1;
        hdr_model[idx].start_addr   = GLB_ADDR_WIDTH'(v[0]);
        hdr_model[idx].num_active   = CNT_WIDTH'(v[1]);
        hdr_model[idx].num_inactive = CNT_WIDTH'(v[2]);
        hdr_model[idx].range        = {CNT_WIDTH'(v[4]), CNT_WIDTH'(v[3])};
        hdr_model[idx].stride       = {CNT_WIDTH'(v[6]), CNT_WIDTH'(v[5])};
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start_pulse <= 1'b1;
        @(posedge clk);
        start_pulse <= 1'b0;
    endtask

    task automatic run_test(input string name, input int idx);
        dma_ld_header_t             h;
        logic [CGRA_DATA_WIDTH-1:0] exp_q [$];
        logic [GLB_ADDR_WIDTH-1:0]  addr;
        bit                         accepted;
        bit                         timed_out;
        int                         n1;
        int                         base;
        int                         dbase;
        int                         waited;
        int                         got;
        int                         exp_gap;
        int                         errs_before;
        int                         ibase [QUEUE_DEPTH];
        h           = hdr_model[idx];
        errs_before = errors;
        timed_out   = 1'b0;
        accepted    = (mode_model != OFF) && h.valid && (h.range[0] != '0);
        // unused outer level runs once
        n1 = (h.range[1] == '0) ? 1 : int'(h.range[1]);
        if (accepted) begin
            for (int i1 = 0; i1 < n1; i1++) begin
                for (int i0 = 0; i0 < int'(h.range[0]); i0++) begin
                    addr = GLB_ADDR_WIDTH'(h.start_addr + i0 * h.stride[0]
                                           + i1 * h.stride[1]);
                    exp_q.push_back(lane_of(addr));
                end
            end
            // repeat keeps the slot, the others consume it
            if (mode_model != REPEAT) begin
                hdr_model[idx].valid = 1'b0;
            end
        end
        base  = got_data.size();
        dbase = done_cnt;
        for (int s = 0; s < QUEUE_DEPTH; s++) begin
            ibase[s] = inv_cnt[s];
        end
        pulse_start();
        for (int k = 0; k < exp_q.size() && !timed_out; k++) begin
            waited = 0;
            while (got_data.size() <= base + k && waited < TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (got_data.size() <= base + k) begin
                $display("test %s: timeout waiting for stream word", name);
                timed_out = 1'b1;
            end
        end
        if (accepted && !timed_out) begin
            waited = 0;
            while (done_cnt == dbase && waited < TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (done_cnt == dbase) begin
                $display("test %s: timeout waiting for done pulse", name);
                timed_out = 1'b1;
            end
        end
        // quiet window, the whole timeout for a start that must be ignored
        waited = accepted ? 8 : TIMEOUT;
        for (int c = 0; c < waited; c++) begin
            @(negedge clk);
        end
        if (timed_out) begin
            errors++;
        end else begin
            got = got_data.size() - base;
            check_count({name, " words"}, exp_q.size(), got);
            for (int k = 0; k < exp_q.size() && k < got; k++) begin
                check_word($sformatf("%s word %0d", name, k), exp_q[k], got_data[base + k]);
                if (k > 0) begin
                    // idle run only at a burst boundary
                    exp_gap = (h.num_active != '0 && k % h.num_active == 0)
                              ? int'(h.num_inactive) : 0;
                    check_gap($sformatf("%s gap %0d", name, k), exp_gap,
                              got_cyc[base + k] - got_cyc[base + k - 1] - 1);
                end
            end
            check_count({name, " done pulses"}, accepted ? 1 : 0, done_cnt - dbase);
            if (accepted && got == exp_q.size()) begin
                check_count({name, " done cycle"}, got_cyc[base + got - 1] + 1, done_cyc);
            end
            for (int s = 0; s < QUEUE_DEPTH; s++) begin
                check_count($sformatf("%s invalidate %0d", name, s),
                            (accepted && mode_model != REPEAT && s == idx) ? 1 : 0,
                            inv_cnt[s] - ibase[s]);
            end
        end
        if (errors == errs_before) begin
            $display("test %s passed", name);
            tests_passed++;
        end else begin
            $display("test %s failed", name);
            tests_failed++;
        end
    endtask

    initial begin
        clk              = 1'b0;
        reset            = 1'b1;
        cfg_mode         = OFF;
        cfg_hdr_wr       = 1'b0;
        cfg_hdr_idx      = '0;
        cfg_start_addr   = '0;
        cfg_num_active   = '0;
        cfg_num_inactive = '0;
        cfg_range0       = '0;
        cfg_range1       = '0;
        cfg_stride0      = '0;
        cfg_stride1      = '0;
        mem_wr_en        = 1'b0;
        mem_wr_addr      = '0;
        mem_wr_data      = '0;
        start_pulse      = 1'b0;
        mode_model       = OFF;
        seed             = 98;
        void'($urandom(seed));
        for (int s = 0; s < QUEUE_DEPTH; s++) begin
            hdr_model[s] = '0;
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        // background fill, word index folded in
        for (int w = 0; w < WORDS; w++) begin
            write_mem(GLB_ADDR_WIDTH'(w << BYTE_OFFSET),
                      {$urandom(), $urandom()} ^ BANK_DATA_WIDTH'(w));
        end
        fd = $fopen("tb/glb_load_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the tests file");
            errors++;
        end else begin
            while ($fscanf(fd, "%s", kind) == 1) begin
                if (kind.getc(0) == "#") begin
                    void'($fgets(line, fd));
                end else if (kind == "mem") begin
                    void'($fscanf(fd, "%h %h", faddr, fdata));
                    write_mem(faddr, fdata);
                end else if (kind == "hdr") begin
                    void'($fscanf(fd, "%d %h %d %d %d %d %d %d", slot, v[0], v[1], v[2],
                                  v[3], v[4], v[5], v[6]));
                    write_hdr(slot);
                end else if (kind == "mode") begin
                    void'($fscanf(fd, "%s", mname));
                    if (mname == "NORMAL") begin
                        mode_model = NORMAL;
                    end else if (mname == "REPEAT") begin
                        mode_model = REPEAT;
                    end else if (mname == "AUTO_INCR") begin
                        mode_model = AUTO_INCR;
                    end else begin
                        mode_model = OFF;
                    end
                    @(posedge clk);
                    cfg_mode <= mode_model;
                end else if (kind == "run") begin
                    void'($fscanf(fd, "%s %d", tname, slot));
                    run_test(tname, slot);
                end else begin
                    $display("unknown entry %s in the tests file", kind);
                    errors++;
                    void'($fgets(line, fd));
                end
            end
            $fclose(fd);
        end
        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* tb/glb_load_tests.txt */
# mem <byte addr hex> <bank word hex> | mode <name> | run <test name> <slot>
# hdr <slot> <start hex> <active> <inactive> <range0> <range1> <stride0> <stride1>
mem 000 0123456789abcdef
mem 008 1122334455667788
mem 010 99aabbccddeeff00
mem 100 0f1e2d3c4b5a6978
mem 108 8796a5b4c3d2e1f0
mem 040 a0a1a2a3a4a5a6a7
mem 048 b0b1b2b3b4b5b6b7
mode NORMAL
hdr 0 000 0 0 12 0 2 0
run linear_normal 0
hdr 0 104 0 0 3 4 4 40
run two_level_stride 0
hdr 0 040 3 2 10 0 2 0
run duty_cycle 0
hdr 0 200 0 0 4 0 8 0
run invalidate_first 0
run invalidate_second 0
mode REPEAT
hdr 0 300 0 0 5 2 2 16
run repeat_first 0
run repeat_second 0
mode AUTO_INCR
hdr 0 080 2 1 6 0 2 0
hdr 1 3a0 0 0 4 2 8 4
run auto_slot0 0
run auto_slot1 1

/* project.f */
hdl/glb_pkg.sv
hdl/glb_rd_if.sv
hdl/glb_load_dma.sv
hdl/glb_bank_router.sv
hdl/glb_bank.sv
hdl/glb_rdrs_merge.sv
hdl/glb_load_top.sv
tb/glb_load_tb.sv

/* Bender.yml */
package:
  name: glb_load

sources:
  - files:
      - hdl/glb_pkg.sv
      - hdl/glb_rd_if.sv
      - hdl/glb_load_dma.sv
      - hdl/glb_bank_router.sv
      - hdl/glb_bank.sv
      - hdl/glb_rdrs_merge.sv
      - hdl/glb_load_top.sv
  - target: test
    files:
      - tb/glb_load_tb.sv
